//--- include/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

////////////////////////////////////////
// datapath sizes
////////////////////////////////////////
`define CPU_DATA_W    8              // register and memory byte
`define CPU_ADDR_W    32             // program counter
`define CPU_REG_N     8              // register file depth
`define CPU_REG_AW    3              // register index bits

// program counter
`define CPU_PC_STEP   32'd4          // bytes per instruction
`define CPU_RESET_PC  32'h0000_0000  // first fetch address

////////////////////////////////////////
// opcodes, top byte of the instruction
////////////////////////////////////////
`define CPU_OP_LOADI  8'h00
`define CPU_OP_MOV    8'h01
`define CPU_OP_ADD    8'h02
`define CPU_OP_SUB    8'h03          // add with negated operand
`define CPU_OP_AND    8'h04
`define CPU_OP_OR     8'h05
`define CPU_OP_J      8'h06
`define CPU_OP_BEQ    8'h07
`define CPU_OP_LWD    8'h08          // address from register
`define CPU_OP_LWI    8'h09          // address from immediate
`define CPU_OP_SWD    8'h0a
`define CPU_OP_SWI    8'h0b
`define CPU_OP_BNE    8'h10          // jump and branch both set

`endif

//--- source/cpu_pkg.sv
`include "cpu_consts.svh"

package cpu_pkg;

    ////////////////////////////////////////
    // instruction word layout
    ////////////////////////////////////////
    typedef struct packed {
        logic [7:0]             opcode;  // bits 31:24
        logic [`CPU_DATA_W-1:0] dest;    // rd, or branch offset
        logic [`CPU_DATA_W-1:0] src1;    // rt
        logic [`CPU_DATA_W-1:0] src2;    // rs, or immediate
    } instr_t;

    // alu function select
    typedef enum logic [2:0] {
        ALU_FWD = 3'd0,  // pass operand two
        ALU_ADD = 3'd1,  // also sub via negate
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3
    } alu_op_t;

    ////////////////////////////////////////
    // decoded controls, 11 bits
    ////////////////////////////////////////
    typedef struct packed {
        logic    reg_write;   // write back to register file
        logic    negate;      // two's complement of operand two
        logic    use_imm;     // immediate replaces operand two
        alu_op_t alu_op;
        logic    jump;
        logic    branch;      // with jump set: branch on not equal
        logic    mem_read;    // read strobe
        logic    mem_write;   // write strobe
        logic    mem_to_reg;  // write back memory data
    } ctrl_t;

endpackage

//--- source/cpu_decoder.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_decoder
    import cpu_pkg::*;
(
    input  logic [7:0] opcode,
    output ctrl_t      ctrl
);

    always_comb
    begin
        ctrl = '0;  // unknown opcodes fall through as a no-op
        case (opcode)
            `CPU_OP_LOADI:
            begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;    // immediate straight through
                ctrl.alu_op    = ALU_FWD;
            end
            `CPU_OP_MOV:
            begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = ALU_FWD;  // copy rs
            end
            `CPU_OP_ADD:
            begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = ALU_ADD;
            end
            `CPU_OP_SUB:
            begin
                ctrl.reg_write = 1'b1;
                ctrl.negate    = 1'b1;    // rt + (-rs)
                ctrl.alu_op    = ALU_ADD;
            end
            `CPU_OP_AND:
            begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = ALU_AND;
            end
            `CPU_OP_OR:
            begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = ALU_OR;
            end
            `CPU_OP_J:       ctrl.jump = 1'b1;  // alu result unused
            `CPU_OP_BEQ:
            begin
                ctrl.negate = 1'b1;       // compare by subtraction
                ctrl.alu_op = ALU_ADD;
                ctrl.branch = 1'b1;
            end
            `CPU_OP_BNE:
            begin
                ctrl.negate = 1'b1;
                ctrl.alu_op = ALU_ADD;
                ctrl.jump   = 1'b1;       // jump+branch means taken on nonzero
                ctrl.branch = 1'b1;
            end
            `CPU_OP_LWD, `CPU_OP_LWI:
            begin
                ctrl.reg_write  = 1'b1;
                ctrl.use_imm    = (opcode == `CPU_OP_LWI);  // address source
                ctrl.alu_op     = ALU_FWD;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;   // load data to rd
            end
            `CPU_OP_SWD, `CPU_OP_SWI:
            begin
                ctrl.use_imm   = (opcode == `CPU_OP_SWI);
                ctrl.alu_op    = ALU_FWD; // address on alu_result
                ctrl.mem_write = 1'b1;    // data is regout1
            end
            default:         ctrl = '0;
        endcase
    end

endmodule

//--- source/cpu_pc.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_pc
(
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic [`CPU_DATA_W-1:0] offset,       // word offset, signed
    input  logic                   jump,
    input  logic                   branch,
    input  logic                   zero,
    input  logic                   busywait,     // data memory stall
    input  logic                   instr_cache_busywait,
    output logic [`CPU_ADDR_W-1:0] pc
);

    logic [`CPU_ADDR_W-1:0] pc_plus4;
    logic [`CPU_ADDR_W-1:0] offset_ext;      // sign extended, times four
    logic [`CPU_ADDR_W-1:0] target;
    logic [`CPU_ADDR_W-1:0] next_pc;
    logic                   take;
    logic                   stall;

    ////////////////////////////////////////
    // next address
    ////////////////////////////////////////
    assign pc_plus4   = pc + `CPU_PC_STEP;
    assign offset_ext = {{(`CPU_ADDR_W-`CPU_DATA_W-2){offset[`CPU_DATA_W-1]}}, offset, 2'b00};
    assign target     = pc_plus4 + offset_ext;

    // j taken always, beq on zero, bne (both set) on not zero
    assign take    = jump ? (~branch | ~zero) : (branch & zero);
    assign next_pc = take ? target : pc_plus4;

    assign stall = busywait | instr_cache_busywait;  // either memory holds the pc

    always_ff @(posedge CLK)
    begin
        if (RESET)
            pc <= `CPU_RESET_PC;
        else if (!stall)
            pc <= next_pc;
    end

endmodule

//--- source/cpu_reg_file.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_reg_file
(
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic [`CPU_DATA_W-1:0] write_data,
    input  logic [`CPU_REG_AW-1:0] write_addr,
    input  logic [`CPU_REG_AW-1:0] read_addr1,
    input  logic [`CPU_REG_AW-1:0] read_addr2,
    input  logic                   write_enable,
    input  logic                   busywait,   // load still pending
    output logic [`CPU_DATA_W-1:0] regout1,
    output logic [`CPU_DATA_W-1:0] regout2
);

    logic [`CPU_DATA_W-1:0] regs [`CPU_REG_N];

    ////////////////////////////////////////
    // two asynchronous read ports
    ////////////////////////////////////////
    assign regout1 = regs[read_addr1];
    assign regout2 = regs[read_addr2];  // operand two, before negate/imm

    // single write port

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            for (int i = 0; i < `CPU_REG_N; i++)
            begin
                regs[i] <= '0;  // all registers start at zero
            end
        end
        else if (write_enable && !busywait)
        begin
            regs[write_addr] <= write_data;  // commits at the last edge of a load
        end
    end

endmodule

//--- source/cpu_alu.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_alu
    import cpu_pkg::*;
(
    input  logic [`CPU_DATA_W-1:0] regout1,    // operand one
    input  logic [`CPU_DATA_W-1:0] regout2,
    input  logic [`CPU_DATA_W-1:0] immediate,
    input  ctrl_t                  ctrl,
    output logic [`CPU_DATA_W-1:0] result,
    output logic                   zero
);

    logic [`CPU_DATA_W-1:0] reg_operand;       // rs, maybe negated
    logic [`CPU_DATA_W-1:0] operand2;

    ////////////////////////////////////////
    // operand two selection
    ////////////////////////////////////////
    always_comb
    begin
        if (ctrl.negate)
            reg_operand = ~regout2 + 1'b1;  // two's complement
        else
            reg_operand = regout2;
    end

    assign operand2 = ctrl.use_imm ? immediate : reg_operand;  // imm wins

    ////////////////////////////////////////
    // functions
    ////////////////////////////////////////
    always_comb
    begin
        case (ctrl.alu_op)
            ALU_FWD: result = operand2;             // loadi, mov, memory address
            ALU_ADD: result = regout1 + operand2;   // add, sub, compare
            ALU_AND: result = regout1 & operand2;
            ALU_OR:  result = regout1 | operand2;
            default: result = '0;
        endcase
    end

    // equal operands give zero after subtraction
    assign zero = (result == '0);

endmodule

//--- source/cpu_top.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_top
    import cpu_pkg::*;
(
    input  logic                   CLK,
    input  logic                   RESET,
    input  instr_t                 instruction,
    input  logic [`CPU_DATA_W-1:0] read_data,
    input  logic                   busywait,             // data memory
    input  logic                   instr_cache_busywait,
    output logic [`CPU_ADDR_W-1:0] pc,
    output logic                   read,
    output logic                   write,
    output logic [`CPU_DATA_W-1:0] regout1,              // store data
    output logic [`CPU_DATA_W-1:0] alu_result            // memory address
);

    ctrl_t                  ctrl;
    logic [`CPU_DATA_W-1:0] regout2;
    logic [`CPU_DATA_W-1:0] write_data;
    logic                   zero;

    ////////////////////////////////////////
    // control and program counter
    ////////////////////////////////////////
    cpu_decoder decoder_inst (.opcode(instruction.opcode), .ctrl(ctrl));

    assign read  = ctrl.mem_read;   // opcode only, no gating
    assign write = ctrl.mem_write;

    cpu_pc pc_inst
    (
        .CLK                  (CLK),
        .RESET                (RESET),
        .offset               (instruction.dest),   // dest byte doubles as offset
        .jump                 (ctrl.jump),
        .branch               (ctrl.branch),
        .zero                 (zero),
        .busywait             (busywait),
        .instr_cache_busywait (instr_cache_busywait),
        .pc                   (pc)
    );

    ////////////////////////////////////////
    // datapath
    ////////////////////////////////////////
    assign write_data = ctrl.mem_to_reg ? read_data : alu_result;  // load vs alu

    cpu_reg_file reg_file_inst
    (
        .CLK          (CLK),
        .RESET        (RESET),
        .write_data   (write_data),
        .write_addr   (instruction.dest[`CPU_REG_AW-1:0]),
        .read_addr1   (instruction.src1[`CPU_REG_AW-1:0]),
        .read_addr2   (instruction.src2[`CPU_REG_AW-1:0]),
        .write_enable (ctrl.reg_write),
        .busywait     (busywait),
        .regout1      (regout1),
        .regout2      (regout2)
    );

    cpu_alu alu_inst
    (
        .regout1   (regout1),
        .regout2   (regout2),
        .immediate (instruction.src2),   // full byte as immediate
        .ctrl      (ctrl),
        .result    (alu_result),
        .zero      (zero)
    );

endmodule

//--- tests/cpu_sva.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_sva
    import cpu_pkg::*;
(
    input logic                   CLK,
    input logic                   RESET,
    input instr_t                 instruction,
    input logic                   busywait,
    input logic                   instr_cache_busywait,
    input logic [`CPU_ADDR_W-1:0] pc,
    input logic                   read,
    input logic                   write,
    input logic [`CPU_DATA_W-1:0] alu_result
);

    int                     fail_count = 0;  // failed assertions so far
    logic                   stall;
    logic                   is_load;
    logic                   is_store;
    logic                   is_flow;
    logic [`CPU_ADDR_W-1:0] jump_target;     // pc+4 plus word offset

    task automatic flag_failure(input string what);
        fail_count++;
        $error("Mismatch at %0t ns: %s", $time, what);
    endtask

    assign stall    = busywait | instr_cache_busywait;
    assign is_load  = instruction.opcode inside {`CPU_OP_LWD, `CPU_OP_LWI};
    assign is_store = instruction.opcode inside {`CPU_OP_SWD, `CPU_OP_SWI};
    assign is_flow  = instruction.opcode inside {`CPU_OP_J, `CPU_OP_BEQ, `CPU_OP_BNE};
    assign jump_target = pc + `CPU_PC_STEP + {{22{instruction.dest[7]}}, instruction.dest, 2'b00};

    ////////////////////////////////////////
    // program counter
    ////////////////////////////////////////
    reset_pc: assert property (@(posedge CLK) RESET |=> pc == `CPU_RESET_PC)
        else flag_failure("pc not at reset address");
    pc_hold: assert property (@(posedge CLK) disable iff (RESET) stall |=> pc == $past(pc))
        else flag_failure("pc moved during a stall");
    pc_step: assert property (@(posedge CLK) disable iff (RESET)
        (!stall && !is_flow) |=> pc == $past(pc) + `CPU_PC_STEP)
        else flag_failure("pc did not step by 4");
    j_target: assert property (@(posedge CLK) disable iff (RESET)
        (!stall && instruction.opcode == `CPU_OP_J) |=> pc == $past(jump_target))
        else flag_failure("j landed off target");

    ////////////////////////////////////////
    // strobes and immediate result
    ////////////////////////////////////////
    strobes: assert property (@(posedge CLK) disable iff (RESET)
        read == is_load && write == is_store)
        else flag_failure("read/write strobe does not match the opcode");
    loadi_result: assert property (@(posedge CLK) disable iff (RESET)
        instruction.opcode == `CPU_OP_LOADI |-> alu_result == instruction.src2)
        else flag_failure("loadi result is not the immediate");

endmodule

//--- tests/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_tb
    import cpu_pkg::*;
();

    localparam int          RESET_CYCLES = 16;
    localparam int          MAX_CYCLES   = 400;        // 25 words, worst ~10 cycles each
    localparam int          PROG_LEN     = 25;
    localparam logic [31:0] HALT_PC      = 32'd96;     // self jump at word 24
    localparam logic [31:0] NOP_WORD     = 32'hff00_0000;

    logic                   CLK;
    logic                   RESET;
    instr_t                 instruction;
    logic [`CPU_DATA_W-1:0] read_data;
    logic                   busywait;
    logic                   instr_cache_busywait;
    logic [`CPU_ADDR_W-1:0] pc;
    logic                   read;
    logic                   write;
    logic [`CPU_DATA_W-1:0] regout1;
    logic [`CPU_DATA_W-1:0] alu_result;

    instr_t                 program_rom [PROG_LEN];
    logic [`CPU_DATA_W-1:0] dmem [256];              // bus side memory
    logic [`CPU_DATA_W-1:0] exp_mem [256];           // expected contents
    logic [`CPU_DATA_W-1:0] shadow [`CPU_REG_N];     // register model
    logic [`CPU_ADDR_W-1:0] exp_pc;
    logic                   halted;
    int                     cycles;
    int                     wait_left;               // busywait cycles to go
    int                     errors;
    int                     checks;
    int                     sva_fails;

    cpu_top cpu_top_inst
    (
        .CLK                  (CLK),
        .RESET                (RESET),
        .instruction          (instruction),
        .read_data            (read_data),
        .busywait             (busywait),
        .instr_cache_busywait (instr_cache_busywait),
        .pc                   (pc),
        .read                 (read),
        .write                (write),
        .regout1              (regout1),
        .alu_result           (alu_result)
    );

    bind cpu_top cpu_sva sva_inst
    (
        .CLK                  (CLK),
        .RESET                (RESET),
        .instruction          (instruction),
        .busywait             (busywait),
        .instr_cache_busywait (instr_cache_busywait),
        .pc                   (pc),
        .read                 (read),
        .write                (write),
        .alu_result           (alu_result)
    );

    initial CLK = 1'b0;
    always #2 CLK = ~CLK;  // 4 ns period

    function automatic instr_t encode(input logic [7:0] op, input logic [7:0] d,
                                      input logic [7:0] s1, input logic [7:0] s2);
        return instr_t'({op, d, s1, s2});
    endfunction

    function automatic instr_t fetch(input logic [31:0] addr);
        int idx;
        idx = int'(addr >> 2);  // word index
        if (idx >= 0 && idx < PROG_LEN)
            return program_rom[idx];
        return instr_t'(NOP_WORD);
    endfunction

    // expected alu output, from the register model
    function automatic logic [7:0] expected_alu(input instr_t ins);
        logic [7:0] a;
        logic [7:0] b;
        a = shadow[ins.src1[2:0]];
        b = shadow[ins.src2[2:0]];
        case (ins.opcode)
            `CPU_OP_LOADI, `CPU_OP_LWI, `CPU_OP_SWI: return ins.src2;  // immediate
            `CPU_OP_MOV, `CPU_OP_LWD, `CPU_OP_SWD:   return b;
            `CPU_OP_ADD:                             return a + b;
            `CPU_OP_SUB:                             return a - b;
            `CPU_OP_AND:                             return a & b;
            `CPU_OP_OR:                              return a | b;
            default:                                 return 8'h00;
        endcase
    endfunction

    function automatic logic branch_taken(input instr_t ins);
        logic same;
        same = (shadow[ins.src1[2:0]] == shadow[ins.src2[2:0]]);
        case (ins.opcode)
            `CPU_OP_J:   return 1'b1;
            `CPU_OP_BEQ: return same;
            `CPU_OP_BNE: return !same;
            default:     return 1'b0;
        endcase
    endfunction

    task automatic report_mismatch(input string msg);
        errors++;
        $display("Mismatch at %0t ns: %s", $time, msg);
    endtask

    task automatic load_program();
        program_rom[0]  = encode(`CPU_OP_LOADI, 8'd1, 8'd0, 8'h05);
        program_rom[1]  = encode(`CPU_OP_LOADI, 8'd2, 8'd0, 8'h03);
        program_rom[2]  = encode(`CPU_OP_ADD,   8'd3, 8'd1, 8'd2);
        program_rom[3]  = encode(`CPU_OP_SUB,   8'd4, 8'd1, 8'd2);
        program_rom[4]  = encode(`CPU_OP_AND,   8'd5, 8'd1, 8'd2);
        program_rom[5]  = encode(`CPU_OP_OR,    8'd6, 8'd1, 8'd2);
        program_rom[6]  = encode(`CPU_OP_MOV,   8'd7, 8'd0, 8'd3);   // shows r3
        program_rom[7]  = encode(`CPU_OP_BEQ,   8'd1, 8'd1, 8'd2);   // not taken
        program_rom[8]  = encode(`CPU_OP_BNE,   8'd1, 8'd1, 8'd2);   // taken
        program_rom[9]  = encode(`CPU_OP_LOADI, 8'd0, 8'd0, 8'hee);  // skipped
        program_rom[10] = encode(`CPU_OP_J,     8'd1, 8'd0, 8'd0);
        program_rom[11] = encode(`CPU_OP_LOADI, 8'd0, 8'd0, 8'hdd);  // skipped
        program_rom[12] = encode(`CPU_OP_LOADI, 8'd0, 8'd0, 8'h10);
        program_rom[13] = encode(`CPU_OP_SWI,   8'd0, 8'd3, 8'h20);
        program_rom[14] = encode(`CPU_OP_SWD,   8'd0, 8'd6, 8'd0);
        program_rom[15] = encode(`CPU_OP_LWI,   8'd1, 8'd0, 8'h20);  // reload of r3
        program_rom[16] = encode(`CPU_OP_LWD,   8'd2, 8'd0, 8'd0);   // reload of r6
        program_rom[17] = encode(`CPU_OP_MOV,   8'd4, 8'd0, 8'd1);
        program_rom[18] = encode(`CPU_OP_BEQ,   8'd1, 8'd1, 8'd3);   // taken
        program_rom[19] = encode(`CPU_OP_LOADI, 8'd0, 8'd0, 8'haa);  // skipped
        program_rom[20] = encode(`CPU_OP_BNE,   8'd1, 8'd1, 8'd3);   // not taken
        program_rom[21] = encode(`CPU_OP_LWI,   8'd6, 8'd0, 8'h44);  // fill pattern
        program_rom[22] = encode(8'h20,         8'd7, 8'd7, 8'd6);   // unknown opcode, r7 kept
        program_rom[23] = encode(`CPU_OP_ADD,   8'd7, 8'd7, 8'd6);   // reads r7 back
        program_rom[24] = encode(`CPU_OP_J,     8'hff, 8'd0, 8'd0);  // halt loop
    endtask

    task automatic update_shadow(input instr_t ins, input logic [7:0] value);
        case (ins.opcode)
            `CPU_OP_LOADI, `CPU_OP_MOV, `CPU_OP_ADD, `CPU_OP_SUB, `CPU_OP_AND, `CPU_OP_OR:
                shadow[ins.dest[2:0]] = value;
            `CPU_OP_LWD, `CPU_OP_LWI:
            begin
                assert (read_data == exp_mem[value])
                    else report_mismatch($sformatf("load [%h] got %h, expected %h",
                                                   value, read_data, exp_mem[value]));
                shadow[ins.dest[2:0]] = exp_mem[value];
            end
            `CPU_OP_SWD, `CPU_OP_SWI: exp_mem[value] = shadow[ins.src1[2:0]];
            default: ;
        endcase
    endtask

    // runs at the rising edge on pre-edge values
    task automatic check_edge();
        instr_t     ins;
        logic [7:0] exp_val;
        ins = instruction;
        if (RESET)
        begin
            for (int i = 0; i < `CPU_REG_N; i++)
                shadow[i] = '0;
            exp_pc = `CPU_RESET_PC;
        end
        else
        begin
            checks++;
            assert (pc == exp_pc)
                else report_mismatch($sformatf("pc %h, expected %h", pc, exp_pc));
            exp_val = expected_alu(ins);
            if (ins.opcode <= `CPU_OP_OR ||
                (ins.opcode >= `CPU_OP_LWD && ins.opcode <= `CPU_OP_SWI))
                assert (alu_result == exp_val)
                    else report_mismatch($sformatf("op %h alu_result %h, expected %h",
                                                   ins.opcode, alu_result, exp_val));
            if (ins.opcode == `CPU_OP_SWD || ins.opcode == `CPU_OP_SWI)
                assert (regout1 == shadow[ins.src1[2:0]])
                    else report_mismatch($sformatf("store data %h, expected %h",
                                                   regout1, shadow[ins.src1[2:0]]));
            if (busywait || instr_cache_busywait)
                exp_pc = pc;  // either memory stalls
            else if (branch_taken(ins))
                exp_pc = pc + `CPU_PC_STEP + {{22{ins.dest[7]}}, ins.dest, 2'b00};
            else
                exp_pc = pc + `CPU_PC_STEP;
            if (!busywait)
                update_shadow(ins, exp_val);  // same edge as the register write
        end
    endtask

    // data memory, 1 to 3 busy cycles per access
    task automatic memory_step();
        if (wait_left > 0)
        begin
            wait_left--;
            if (wait_left == 0)
            begin
                busywait = 1'b0;
                if (read)
                    read_data = dmem[alu_result];
                else if (write)
                    dmem[alu_result] = regout1;
            end
        end
        else if (!RESET && (read || write))
        begin
            wait_left = 1 + ($urandom % 3);
            busywait  = 1'b1;
        end
    endtask

    ////////////////////////////////////////
    // stimulus and models
    ////////////////////////////////////////
    initial
    begin
        void'($urandom(74));
        RESET                = 1'b1;
        instruction          = instr_t'(NOP_WORD);
        read_data            = '0;
        busywait             = 1'b0;
        instr_cache_busywait = 1'b0;
        exp_pc               = '0;
        halted               = 1'b0;
        cycles               = 0;
        wait_left            = 0;
        errors               = 0;
        checks               = 0;
        load_program();
        for (int a = 0; a < 256; a++)
        begin
            dmem[a]    = 8'(a * 37 + 11);  // odd multiplier, every address distinct
            exp_mem[a] = dmem[a];
        end
        forever
        begin
            @(posedge CLK);
            cycles++;
            check_edge();
            if (!RESET && pc == HALT_PC)
                halted = 1'b1;
            #1;
            RESET                = (cycles < RESET_CYCLES);
            instruction          = RESET ? instr_t'(NOP_WORD) : fetch(pc);
            instr_cache_busywait = !RESET && !instr_cache_busywait && (($urandom % 6) == 0);
            #1;
            memory_step();  // strobes settled by now
        end
    end

    ////////////////////////////////////////
    // end of run
    ////////////////////////////////////////
    initial
    begin
        @(negedge CLK);
        while (!halted && cycles < MAX_CYCLES)
            @(negedge CLK);
        if (halted)
            repeat (4) @(negedge CLK);  // a few turns of the halt loop
        else
            $display("Timeout: pc did not reach the halt loop within %0d cycles", MAX_CYCLES);
        sva_fails = cpu_top_inst.sva_inst.fail_count;
        $display("cycles checked: %0d, testbench errors: %0d, assertion failures: %0d",
                 checks, errors, sva_fails);
        if (halted && errors == 0 && sva_fails == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+include
source/cpu_pkg.sv
source/cpu_decoder.sv
source/cpu_pc.sv
source/cpu_reg_file.sv
source/cpu_alu.sv
source/cpu_top.sv
tests/cpu_sva.sv
tests/cpu_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module cpu_tb -f verilog.f -o cpu_sim || exit 1
out=$(./obj_dir/cpu_sim +verilator+error+limit+1000)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "ALL CHECKS PASSED" && exit 0 || exit 1
